// ==== nes_audio_settings.svh ====
`ifndef NES_AUDIO_SETTINGS_SVH
`define NES_AUDIO_SETTINGS_SVH

// Work RAM is 2 kB, mirrored through $0000 to $1FFF
`define RAM_SIZE_LOG2 11

// Channel registers at $4010 to $4015
`define REG_BASE 16'h4010

// Computed startup ROM from here to the top of the map
`define ROM_BASE 16'h8000

// Sample start address origin for $4012
`define SAMPLE_BASE 16'hC000

// Sample buffer between fetcher and output unit
`define DMC_FIFO_DEPTH 4

// Cycles per rate step, scaled by (rate + 1)
`define DMC_RATE_UNIT 8

`endif

// ==== nes_audio_pkg.sv ====
package nes_audio_pkg;

// Bus widths
typedef logic [15:0] bus_addr_t;
typedef logic [7:0] bus_data_t;

// One system bus request, held by the requester until its rdy
typedef struct packed {
	bus_addr_t addr;
	logic we;
	bus_data_t wdata;
} bus_req_t;

// Register strobe from the decoder to the channel
typedef struct packed {
	logic wr;
	logic rd;
	logic [2:0] idx;
	bus_data_t wdata;
} reg_access_t;

// Delta channel quantities
typedef logic [6:0] audio_level_t;
typedef logic [3:0] dmc_rate_t;
typedef logic [11:0] dmc_len_t;

// Sample fetcher states
typedef enum logic [1:0] {
	IDLE,
	REQUEST,
	WRITE_BACK
} fetch_state_t;

endpackage

// ==== bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
	input logic sys,
	input logic reset,
	input logic cpu_req,
	input logic dmc_req,
	input nes_audio_pkg::bus_req_t cpu_bus,
	input nes_audio_pkg::bus_req_t dmc_bus,
	input logic rdy,
	output logic grant,
	output nes_audio_pkg::bus_req_t grant_bus,
	output logic cpu_rdy,
	output logic dmc_rdy
);

// Access in flight, and who owns it
logic busy;
logic owner_dmc;

// Fixed priority, fetcher first
assign grant = !busy && (cpu_req || dmc_req);
assign grant_bus = dmc_req ? dmc_bus : cpu_bus;

always_ff @(posedge sys) begin
	if (reset) begin
		busy <= 1'b0;
		owner_dmc <= 1'b0;
	end else if (grant) begin
		busy <= 1'b1;
		owner_dmc <= dmc_req;
	end else if (rdy) begin
		// Bus free again from the next cycle
		busy <= 1'b0;
	end
end

// Route the memory's ready back to the granted requester
assign cpu_rdy = rdy && busy && !owner_dmc;
assign dmc_rdy = rdy && busy && owner_dmc;

endmodule

// ==== bus_memory.sv ====
`timescale 1ns/1ps
`include "nes_audio_settings.svh"

module bus_memory (
	input logic sys,
	input logic reset,
	input logic grant,
	input nes_audio_pkg::bus_req_t grant_bus,
	output logic rdy,
	output nes_audio_pkg::bus_data_t rdata,
	output nes_audio_pkg::reg_access_t reg_acc,
	input nes_audio_pkg::bus_data_t reg_rdata
);

localparam int RAM_WORDS = 2 ** `RAM_SIZE_LOG2;

nes_audio_pkg::bus_data_t ram [RAM_WORDS];

logic ram_sel, reg_sel, rom_sel;
nes_audio_pkg::bus_addr_t reg_off;
nes_audio_pkg::bus_data_t rom_byte;
nes_audio_pkg::bus_data_t read_byte;

// Region decode
assign ram_sel = grant_bus.addr[15:13] == 3'b000;
assign reg_off = grant_bus.addr - `REG_BASE;
assign reg_sel = reg_off < 16'd6;
assign rom_sel = grant_bus.addr >= `ROM_BASE;

// ROM contents are computed from the address
assign rom_byte = grant_bus.addr[7:0] ^ {1'b0, grant_bus.addr[14:8]};

// Register strobes in the grant cycle
assign reg_acc.wr = grant && reg_sel && grant_bus.we;
assign reg_acc.rd = grant && reg_sel && !grant_bus.we;
assign reg_acc.idx = reg_off[2:0];
assign reg_acc.wdata = grant_bus.wdata;

always_comb begin
	if (ram_sel) begin
		read_byte = ram[grant_bus.addr[`RAM_SIZE_LOG2-1:0]];
	end else if (reg_sel) begin
		read_byte = reg_rdata;
	end else if (rom_sel) begin
		read_byte = rom_byte;
	end else begin
		// Unmapped space reads as zero
		read_byte = 8'h00;
	end
end

always_ff @(posedge sys) begin
	if (grant && ram_sel && grant_bus.we) begin
		ram[grant_bus.addr[`RAM_SIZE_LOG2-1:0]] <= grant_bus.wdata;
	end
	if (grant) begin
		rdata <= read_byte;
	end
end

// One-cycle ready after every grant
always_ff @(posedge sys) begin
	if (reset) begin
		rdy <= 1'b0;
	end else begin
		rdy <= grant;
	end
end

endmodule

// ==== dmc_fetcher.sv ====
`timescale 1ns/1ps
`include "nes_audio_settings.svh"

module dmc_fetcher (
	input logic sys,
	input logic reset,
	input nes_audio_pkg::reg_access_t reg_acc,
	output nes_audio_pkg::bus_data_t reg_rdata,
	output logic bus_req,
	output nes_audio_pkg::bus_req_t bus,
	input logic bus_rdy,
	input nes_audio_pkg::bus_data_t rdata,
	input logic fifo_full,
	output logic push,
	output nes_audio_pkg::bus_data_t push_data,
	output nes_audio_pkg::dmc_rate_t rate,
	output logic load,
	output nes_audio_pkg::audio_level_t load_level,
	output logic irq
);

nes_audio_pkg::fetch_state_t state;
logic irq_en, loop;
// Set when $4015 is written as a fetch starts
logic drop;
logic [7:0] addr_reg, len_reg;
nes_audio_pkg::bus_addr_t cur_addr, fetch_addr, start_addr, next_addr;
nes_audio_pkg::dmc_len_t bytes_left, start_len;
nes_audio_pkg::bus_data_t sample_q;
logic wr_ctrl, wr_addr, wr_len, wr_status;

assign wr_ctrl = reg_acc.wr && reg_acc.idx == 3'd0;
assign load = reg_acc.wr && reg_acc.idx == 3'd1;
assign wr_addr = reg_acc.wr && reg_acc.idx == 3'd2;
assign wr_len = reg_acc.wr && reg_acc.idx == 3'd3;
assign wr_status = reg_acc.wr && reg_acc.idx == 3'd5;
assign load_level = reg_acc.wdata[6:0];

// Status read, only $4015 answers
assign reg_rdata = (reg_acc.rd && reg_acc.idx == 3'd5) ?
	{irq, 2'b00, bytes_left != '0, 4'h0} : 8'h00;

assign start_addr = `SAMPLE_BASE + {2'b00, addr_reg, 6'b000000};
assign start_len = {len_reg, 4'h0} + 12'd1;
// Address wraps from the top of the map back into ROM
assign next_addr = (cur_addr == 16'hFFFF) ? `ROM_BASE : cur_addr + 16'd1;

assign bus_req = state == nes_audio_pkg::REQUEST;
assign bus.addr = fetch_addr;
assign bus.we = 1'b0;
assign bus.wdata = 8'h00;

assign push = state == nes_audio_pkg::WRITE_BACK && !drop;
assign push_data = sample_q;

always_ff @(posedge sys) begin
	if (state == nes_audio_pkg::IDLE) begin
		fetch_addr <= cur_addr;
	end
	if (state == nes_audio_pkg::REQUEST && bus_rdy) begin
		sample_q <= rdata;
	end
end

always_ff @(posedge sys) begin
	if (reset) begin
		state <= nes_audio_pkg::IDLE;
		irq_en <= 1'b0;
		loop <= 1'b0;
		rate <= '0;
		addr_reg <= 8'h00;
		len_reg <= 8'h00;
		cur_addr <= `SAMPLE_BASE;
		bytes_left <= '0;
		irq <= 1'b0;
		drop <= 1'b0;
	end else begin
		case (state)
		nes_audio_pkg::IDLE: begin
			drop <= 1'b0;
			if (bytes_left != '0 && !fifo_full) begin
				state <= nes_audio_pkg::REQUEST;
			end
		end
		nes_audio_pkg::REQUEST: begin
			if (bus_rdy) begin
				state <= nes_audio_pkg::WRITE_BACK;
			end
		end
		nes_audio_pkg::WRITE_BACK: begin
			state <= nes_audio_pkg::IDLE;
			if (!drop) begin
				if (bytes_left == 12'd1) begin
					// Last byte of the sample
					if (loop) begin
						cur_addr <= start_addr;
						bytes_left <= start_len;
					end else begin
						bytes_left <= '0;
						if (irq_en) begin
							irq <= 1'b1;
						end
					end
				end else begin
					cur_addr <= next_addr;
					bytes_left <= bytes_left - 12'd1;
				end
			end
		end
		default: state <= nes_audio_pkg::IDLE;
		endcase

		// CPU writes take priority over the fetch update
		if (wr_ctrl) begin
			irq_en <= reg_acc.wdata[7];
			loop <= reg_acc.wdata[6];
			rate <= reg_acc.wdata[3:0];
			if (!reg_acc.wdata[7]) begin
				irq <= 1'b0;
			end
		end
		if (wr_addr) begin
			addr_reg <= reg_acc.wdata;
		end
		if (wr_len) begin
			len_reg <= reg_acc.wdata;
		end
		if (wr_status) begin
			irq <= 1'b0;
			drop <= state == nes_audio_pkg::IDLE && bytes_left != '0 && !fifo_full;
			if (reg_acc.wdata[4]) begin
				cur_addr <= start_addr;
				bytes_left <= start_len;
			end else begin
				bytes_left <= '0;
			end
		end
	end
end

endmodule

// ==== sample_fifo.sv ====
`timescale 1ns/1ps
`include "nes_audio_settings.svh"

module sample_fifo (
	input logic sys,
	input logic reset,
	input logic push,
	input nes_audio_pkg::bus_data_t push_data,
	input logic pop,
	output nes_audio_pkg::bus_data_t head,
	output logic empty,
	output logic full
);

localparam int DEPTH = `DMC_FIFO_DEPTH;
localparam int PTR_W = $clog2(DEPTH);
localparam int CNT_W = $clog2(DEPTH + 1);

nes_audio_pkg::bus_data_t mem [DEPTH];
logic [PTR_W-1:0] rd_ptr, wr_ptr;
logic [CNT_W-1:0] count;
logic do_push, do_pop;

assign empty = count == '0;
assign full = count == CNT_W'(DEPTH);
// Show-ahead, head is valid whenever not empty
assign head = mem[rd_ptr];

// A full FIFO still takes a push when a pop frees a slot
assign do_pop = pop && !empty;
assign do_push = push && (!full || do_pop);

always_ff @(posedge sys) begin
	if (do_push) begin
		mem[wr_ptr] <= push_data;
	end
end

always_ff @(posedge sys) begin
	if (reset) begin
		rd_ptr <= '0;
		wr_ptr <= '0;
		count <= '0;
	end else begin
		if (do_push) begin
			wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
		end
		if (do_pop) begin
			rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
		end
		if (do_push && !do_pop) begin
			count <= count + 1'b1;
		end else if (do_pop && !do_push) begin
			count <= count - 1'b1;
		end
	end
end

endmodule

// ==== delta_output.sv ====
`timescale 1ns/1ps
`include "nes_audio_settings.svh"

module delta_output (
	input logic sys,
	input logic reset,
	input nes_audio_pkg::dmc_rate_t rate,
	input logic load,
	input nes_audio_pkg::audio_level_t load_level,
	input nes_audio_pkg::bus_data_t head,
	input logic empty,
	output logic pop,
	output logic [7:0] audio
);

logic [7:0] timer, reload;
logic tick;
nes_audio_pkg::bus_data_t shift;
logic [2:0] bit_cnt;
// No byte in the shifter, level holds
logic silence;
nes_audio_pkg::audio_level_t level;

// Step length is (rate + 1) rate units
assign reload = ({4'h0, rate} + 8'd1) * 8'(`DMC_RATE_UNIT) - 8'd1;
assign tick = timer == 8'd0;

// Next byte is taken after the eighth bit
assign pop = tick && bit_cnt == 3'd7 && !empty;

assign audio = {level, 1'b0};

always_ff @(posedge sys) begin
	if (pop) begin
		shift <= head;
	end else if (tick) begin
		shift <= {1'b0, shift[7:1]};
	end
end

always_ff @(posedge sys) begin
	if (reset) begin
		timer <= 8'd0;
		bit_cnt <= 3'd0;
		silence <= 1'b1;
		level <= '0;
	end else begin
		timer <= tick ? reload : timer - 8'd1;
		if (tick) begin
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7) begin
				silence <= empty;
			end
			// LSB first, saturating at both ends
			if (!silence) begin
				if (shift[0] && level <= 7'd125) begin
					level <= level + 7'd2;
				end else if (!shift[0] && level >= 7'd2) begin
					level <= level - 7'd2;
				end
			end
		end
		// Direct load from $4011 wins
		if (load) begin
			level <= load_level;
		end
	end
end

endmodule

// ==== nes_audio.sv ====
`timescale 1ns/1ps

module nes_audio (
	input logic sys,
	input logic reset,
	input logic cpu_req,
	input nes_audio_pkg::bus_req_t cpu_bus,
	output logic cpu_rdy,
	output nes_audio_pkg::bus_data_t cpu_rdata,
	output logic [7:0] audio,
	output logic irq
);

// System bus
logic grant, rdy;
nes_audio_pkg::bus_req_t grant_bus;
nes_audio_pkg::bus_data_t rdata;

// Fetcher side of the bus
logic dmc_req, dmc_rdy;
nes_audio_pkg::bus_req_t dmc_bus;

// Channel registers
nes_audio_pkg::reg_access_t reg_acc;
nes_audio_pkg::bus_data_t reg_rdata;
nes_audio_pkg::dmc_rate_t rate;
logic load;
nes_audio_pkg::audio_level_t load_level;

// Sample buffer
logic push, pop, empty, full;
nes_audio_pkg::bus_data_t push_data, head;

assign cpu_rdata = rdata;

bus_arbiter bus_arbiter_i (
	.sys(sys), .reset(reset),
	.cpu_req(cpu_req), .dmc_req(dmc_req),
	.cpu_bus(cpu_bus), .dmc_bus(dmc_bus),
	.rdy(rdy), .grant(grant), .grant_bus(grant_bus),
	.cpu_rdy(cpu_rdy), .dmc_rdy(dmc_rdy));

bus_memory bus_memory_i (
	.sys(sys), .reset(reset),
	.grant(grant), .grant_bus(grant_bus),
	.rdy(rdy), .rdata(rdata),
	.reg_acc(reg_acc), .reg_rdata(reg_rdata));

dmc_fetcher dmc_fetcher_i (
	.sys(sys), .reset(reset),
	.reg_acc(reg_acc), .reg_rdata(reg_rdata),
	.bus_req(dmc_req), .bus(dmc_bus), .bus_rdy(dmc_rdy), .rdata(rdata),
	.fifo_full(full), .push(push), .push_data(push_data),
	.rate(rate), .load(load), .load_level(load_level), .irq(irq));

sample_fifo sample_fifo_i (
	.sys(sys), .reset(reset),
	.push(push), .push_data(push_data),
	.pop(pop), .head(head), .empty(empty), .full(full));

delta_output delta_output_i (
	.sys(sys), .reset(reset),
	.rate(rate), .load(load), .load_level(load_level),
	.head(head), .empty(empty), .pop(pop), .audio(audio));

endmodule

// ==== tb_nes_audio.sv ====
`timescale 1ns/1ps
`include "nes_audio_settings.svh"

module tb_nes_audio;

localparam int DRIVE_DELAY = 1;
localparam int BUS_TIMEOUT = 32;
localparam int IRQ_TIMEOUT = 1000;
localparam int PLAY_TIMEOUT = 8000;

logic sys = 1'b0;
logic reset;
logic cpu_req;
nes_audio_pkg::bus_req_t cpu_bus;
logic cpu_rdy;
nes_audio_pkg::bus_data_t cpu_rdata;
logic [7:0] audio;
logic irq;

int checks = 0;
int errors = 0;
int timeouts = 0;
logic [31:0] rng = 32'hcfd77b52;
nes_audio_pkg::audio_level_t expect_levels[$];

nes_audio nes_audio_i (
	.sys(sys), .reset(reset),
	.cpu_req(cpu_req), .cpu_bus(cpu_bus),
	.cpu_rdy(cpu_rdy), .cpu_rdata(cpu_rdata),
	.audio(audio), .irq(irq));

always #4 sys = ~sys;

function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// ROM byte is the low address byte XOR the high byte without bit 15
function automatic nes_audio_pkg::bus_data_t rom_model(input nes_audio_pkg::bus_addr_t a);
	nes_audio_pkg::bus_data_t hi;
	hi = a[15:8] & 8'h7F;
	return a[7:0] ^ hi;
endfunction

// A step that would leave the 7-bit range keeps the level
function automatic nes_audio_pkg::audio_level_t step_level(
	input nes_audio_pkg::audio_level_t lvl, input logic b);
	int v;
	v = lvl;
	if (b) begin
		v = v + 2;
	end else begin
		v = v - 2;
	end
	if (v < 0 || v > 127) begin
		return lvl;
	end
	return nes_audio_pkg::audio_level_t'(v);
endfunction

// Level changes of a whole sample, bits LSB first, unchanged steps left out
task automatic model_playback(input nes_audio_pkg::bus_addr_t start, input int len,
	input nes_audio_pkg::audio_level_t first);
	nes_audio_pkg::bus_addr_t a;
	nes_audio_pkg::audio_level_t lvl, nxt;
	nes_audio_pkg::bus_data_t b;
	expect_levels.delete();
	a = start;
	lvl = first;
	for (int i = 0; i < len; i++) begin
		b = rom_model(a);
		for (int k = 0; k < 8; k++) begin
			nxt = step_level(lvl, b[k]);
			if (nxt != lvl) begin
				expect_levels.push_back(nxt);
			end
			lvl = nxt;
		end
		a = (a == 16'hFFFF) ? `ROM_BASE : a + 16'd1;
	end
endtask

task automatic check_data(input string name, input nes_audio_pkg::bus_data_t got,
	input nes_audio_pkg::bus_data_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("CHECK FAILED at %0t: %s got %02h, expected %02h", $time, name, got, exp);
	end
endtask

task automatic check_level(input string name, input nes_audio_pkg::audio_level_t got,
	input nes_audio_pkg::audio_level_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("CHECK FAILED at %0t: %s got %0d, expected %0d", $time, name, got, exp);
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("CHECK FAILED at %0t: %s got %b, expected %b", $time, name, got, exp);
	end
endtask

task automatic report_timeout(input string what);
	timeouts++;
	$display("Timeout at %0t: %s", $time, what);
endtask

// Request held until cpu_rdy, read data taken in the rdy cycle
task automatic bus_access(input nes_audio_pkg::bus_addr_t addr, input logic we,
	input nes_audio_pkg::bus_data_t wdata, output nes_audio_pkg::bus_data_t rdata);
	logic done;
	done = 1'b0;
	rdata = 8'h00;
	@(posedge sys);
	#DRIVE_DELAY;
	cpu_req = 1'b1;
	cpu_bus.addr = addr;
	cpu_bus.we = we;
	cpu_bus.wdata = wdata;
	for (int n = 0; n < BUS_TIMEOUT && !done; n++) begin
		@(negedge sys);
		if (cpu_rdy) begin
			done = 1'b1;
			rdata = cpu_rdata;
		end
	end
	@(posedge sys);
	#DRIVE_DELAY;
	cpu_req = 1'b0;
	if (!done) begin
		report_timeout($sformatf("no cpu_rdy for the access at %04h", addr));
	end
endtask

task automatic bus_write(input nes_audio_pkg::bus_addr_t addr,
	input nes_audio_pkg::bus_data_t data);
	nes_audio_pkg::bus_data_t unused;
	bus_access(addr, 1'b1, data, unused);
endtask

task automatic bus_read(input nes_audio_pkg::bus_addr_t addr,
	output nes_audio_pkg::bus_data_t data);
	bus_access(addr, 1'b0, 8'h00, data);
endtask

task automatic ram_round(input nes_audio_pkg::bus_addr_t addr);
	nes_audio_pkg::bus_data_t d, got;
	rng = xorshift(rng);
	d = rng[23:16];
	bus_write(addr, d);
	bus_read(addr, got);
	check_data($sformatf("ram %04h", addr), got, d);
	bus_read(addr + 16'h0800, got);
	check_data($sformatf("ram mirror %04h", addr + 16'h0800), got, d);
endtask

task automatic test_ram();
	for (int i = 0; i < 16; i++) begin
		rng = xorshift(rng);
		ram_round({5'b00000, rng[10:0]});
	end
endtask

task automatic test_rom();
	nes_audio_pkg::bus_addr_t a;
	nes_audio_pkg::bus_data_t got;
	for (int i = 0; i < 16; i++) begin
		rng = xorshift(rng);
		a = `ROM_BASE | {1'b0, rng[14:0]};
		bus_read(a, got);
		check_data($sformatf("rom %04h", a), got, rom_model(a));
	end
	// Hole between the registers and the ROM
	bus_read(16'h6000, got);
	check_data("unmapped 6000", got, 8'h00);
endtask

task automatic test_direct_load();
	nes_audio_pkg::bus_data_t v;
	rng = xorshift(rng);
	v = rng[7:0];
	bus_write(16'h4011, v);
	check_data("audio after load", audio, {v[6:0], 1'b0});
	repeat (100) @(negedge sys);
	check_level("level held", audio[7:1], v[6:0]);
endtask

task automatic test_playback();
	nes_audio_pkg::audio_level_t seen[$];
	nes_audio_pkg::audio_level_t first, prev;
	nes_audio_pkg::bus_addr_t start;
	rng = xorshift(rng);
	first = rng[6:0];
	// Last 64-byte block, so the sample runs past $FFFF into $8000
	start = `SAMPLE_BASE + 16'h00FF * 16'd64;
	model_playback(start, 8'h04 * 16 + 1, first);
	bus_write(16'h4010, 8'h00);
	bus_write(16'h4012, 8'hFF);
	bus_write(16'h4013, 8'h04);
	bus_write(16'h4011, {1'b0, first});
	bus_write(16'h4015, 8'h10);
	prev = first;
	for (int n = 0; n < PLAY_TIMEOUT + 300 && seen.size() <= expect_levels.size(); n++) begin
		@(negedge sys);
		if (audio[7:1] != prev) begin
			prev = audio[7:1];
			seen.push_back(prev);
		end
		if (n == PLAY_TIMEOUT && seen.size() < expect_levels.size()) begin
			report_timeout("playback stopped before the last level change");
		end
	end
	checks++;
	if (seen.size() != expect_levels.size()) begin
		errors++;
		$display("Playback gave %0d level changes where the model has %0d",
			seen.size(), expect_levels.size());
	end
	for (int i = 0; i < seen.size() && i < expect_levels.size(); i++) begin
		check_level($sformatf("level change %0d", i), seen[i], expect_levels[i]);
	end
endtask

task automatic test_interrupt();
	nes_audio_pkg::bus_data_t got;
	bus_write(16'h4010, 8'h80);
	bus_write(16'h4013, 8'h00);
	bus_write(16'h4015, 8'h10);
	for (int n = 0; n < IRQ_TIMEOUT && !irq; n++) begin
		@(negedge sys);
	end
	if (!irq) begin
		report_timeout("irq did not rise after the last byte");
	end
	bus_read(16'h4015, got);
	check_data("status after end", got, 8'h80);
	check_bit("irq before clear", irq, 1'b1);
	bus_write(16'h4015, 8'h00);
	check_bit("irq after clear", irq, 1'b0);
	// Looping sample never runs out of bytes, so irq stays low
	bus_write(16'h4010, 8'hC0);
	bus_write(16'h4015, 8'h10);
	for (int i = 0; i < 3; i++) begin
		repeat (100) @(negedge sys);
		bus_read(16'h4015, got);
		check_data("status while looping", got, 8'h10);
	end
	check_bit("irq after loop", irq, 1'b0);
	bus_write(16'h4015, 8'h00);
	bus_read(16'h4015, got);
	check_data("status after stop", got, 8'h00);
endtask

task automatic test_contention();
	nes_audio_pkg::bus_addr_t a;
	nes_audio_pkg::bus_data_t got;
	rng = xorshift(rng);
	bus_write(16'h4012, rng[7:0]);
	bus_write(16'h4013, 8'h00);
	bus_write(16'h4010, 8'h40);
	bus_write(16'h4015, 8'h10);
	for (int i = 0; i < 16; i++) begin
		rng = xorshift(rng);
		ram_round({5'b00000, rng[10:0]});
		a = `ROM_BASE | {1'b0, rng[30:16]};
		bus_read(a, got);
		check_data($sformatf("rom %04h under playback", a), got, rom_model(a));
	end
	bus_write(16'h4015, 8'h00);
endtask

initial begin
	reset = 1'b1;
	cpu_req = 1'b0;
	cpu_bus = '0;
	repeat (8) @(posedge sys);
	#DRIVE_DELAY;
	reset = 1'b0;
	@(negedge sys);
	check_bit("cpu_rdy after reset", cpu_rdy, 1'b0);
	check_bit("irq after reset", irq, 1'b0);
	check_data("audio after reset", audio, 8'h00);
	test_ram();
	test_rom();
	test_direct_load();
	test_playback();
	test_interrupt();
	test_contention();
	$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
	if (errors == 0 && timeouts == 0) begin
		$display("TB PASSED");
	end else begin
		$display("TB FAILED");
	end
	$finish;
end

endmodule

// ==== nes_audio.f ====
+incdir+.
nes_audio_pkg.sv
bus_arbiter.sv
bus_memory.sv
dmc_fetcher.sv
sample_fifo.sv
delta_output.sv
nes_audio.sv
tb_nes_audio.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f nes_audio.f --top-module tb_nes_audio -Mdir obj_dir
	./obj_dir/Vtb_nes_audio | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
